//--- Makefile
TOP := rv_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- rtl/rv_alu.sv
// Combinational ALU. The operation is the funct3 code of the instruction,
// with sub and arith as modifiers. Compare flags are always produced for branches.
`default_nettype none
`timescale 1ns/100ps

`include "rv_consts.svh"

module rv_alu (
  input  rv_pkg::alu_req_t req,
  output rv_pkg::alu_rsp_t rsp
);

  rv_pkg::word_t sum;
  rv_pkg::word_t sra;
  logic          lt;
  logic          ltu;

  assign sum = req.sub ? req.a - req.b : req.a + req.b;
  assign sra = rv_pkg::word_t'($signed(req.a) >>> req.shamt);
  assign lt  = $signed(req.a) < $signed(req.b);
  assign ltu = req.a < req.b;

  always_comb begin
    rsp.eq  = (req.a == req.b);
    rsp.lt  = lt;
    rsp.ltu = ltu;
    rsp.res = sum;
    case (req.op)
      `RV_F3_ADD:  rsp.res = sum;
      `RV_F3_SLL:  rsp.res = req.a << req.shamt;
      `RV_F3_SLT:  rsp.res = {{(`RV_XLEN-1){1'b0}}, lt};
      `RV_F3_SLTU: rsp.res = {{(`RV_XLEN-1){1'b0}}, ltu};
      `RV_F3_XOR:  rsp.res = req.a ^ req.b;
      `RV_F3_SR:   rsp.res = req.arith ? sra : req.a >> req.shamt;
      `RV_F3_OR:   rsp.res = req.a | req.b;
      `RV_F3_AND:  rsp.res = req.a & req.b;
      default:     rsp.res = sum;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/rv_consts.svh
// Widths, opcodes, funct3 codes and instruction field positions for the RV32I core.
// Included by the package and by every RTL file that needs a constant.
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN      32
`define RV_REG_W     5
`define RV_MEM_AW    14           // Byte address bits seen by the memory
`define RV_PC_STEP   4
`define RV_RESET_PC  32'h0000_0000

`define RV_OP_ARITH  7'b0110011
`define RV_OP_IARITH 7'b0010011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_LUI    7'b0110111
`define RV_OP_JAL    7'b1101111

`define RV_F3_ADD    3'b000
`define RV_F3_SLL    3'b001
`define RV_F3_SLT    3'b010
`define RV_F3_SLTU   3'b011
`define RV_F3_XOR    3'b100
`define RV_F3_SR     3'b101
`define RV_F3_OR     3'b110
`define RV_F3_AND    3'b111
`define RV_F3_BEQ    3'b000
`define RV_F3_BNE    3'b001
`define RV_F3_BLT    3'b100
`define RV_F3_BGE    3'b101
`define RV_F3_BLTU   3'b110
`define RV_F3_BGEU   3'b111
`define RV_F3_LW     3'b010
`define RV_F3_SW     3'b010

// Field positions in the instruction word
`define RV_OPC_LSB   0
`define RV_RD_LSB    7
`define RV_F3_LSB    12
`define RV_RS1_LSB   15
`define RV_RS2_LSB   20
`define RV_F7_LSB    25
`define RV_ALT_BIT   30           // sub and arithmetic shift
`define RV_SIGN_BIT  31

`endif

//--- rtl/rv_control.sv
// Stage controller of the multi-cycle core. Walks each instruction through
// FETCH, REG, EXEC, RESOLVE and MEM, holds pc, ir and the memory bus registers,
// and steers the ALU and the register file.
`default_nettype none
`timescale 1ns/100ps

`include "rv_consts.svh"

module rv_control (
  input  logic             clk,
  input  logic             rstn,
  input  rv_pkg::dec_t     dec,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  input  rv_pkg::alu_rsp_t alu_rsp,
  input  rv_pkg::word_t    mem_rdata,
  output rv_pkg::word_t    ir,
  output rv_pkg::alu_req_t alu_req,
  output rv_pkg::rf_req_t  rf_req,
  output rv_pkg::mem_req_t mem_req
);

  rv_pkg::stage_e stage;
  rv_pkg::addr_t  pc;
  rv_pkg::addr_t  pc_step;
  rv_pkg::addr_t  jump_sum;
  rv_pkg::addr_t  link;      // Return address, also the fall-through pc
  rv_pkg::addr_t  target;    // Pending branch target
  logic           taken;
  logic           ends_in_reg;

  assign pc_step  = pc + `RV_PC_STEP;
  assign jump_sum = pc + ((dec.opcode == `RV_OP_JAL) ? dec.j_imm : dec.b_imm);

  always_comb begin
    case (dec.funct3)
      `RV_F3_BEQ:  taken = alu_rsp.eq;
      `RV_F3_BNE:  taken = !alu_rsp.eq;
      `RV_F3_BLT:  taken = alu_rsp.lt;
      `RV_F3_BGE:  taken = !alu_rsp.lt;
      `RV_F3_BLTU: taken = alu_rsp.ltu;
      `RV_F3_BGEU: taken = !alu_rsp.ltu;
      default:     taken = 1'b0;
    endcase
  end

  // LUI and anything unsupported finish in REG
  always_comb begin
    case (dec.opcode)
      `RV_OP_ARITH, `RV_OP_IARITH, `RV_OP_BRANCH, `RV_OP_JAL: ends_in_reg = 1'b0;
      `RV_OP_LOAD:  ends_in_reg = (dec.funct3 != `RV_F3_LW);
      `RV_OP_STORE: ends_in_reg = (dec.funct3 != `RV_F3_SW);
      default:      ends_in_reg = 1'b1;
    endcase
  end

  always_comb begin
    rf_req.rs1   = dec.rs1;
    rf_req.rs2   = dec.rs2;
    rf_req.rd    = dec.rd;
    rf_req.we    = 1'b0;
    rf_req.wdata = alu_rsp.res;
    case (stage)
      rv_pkg::REG: begin
        rf_req.we    = (dec.opcode == `RV_OP_LUI);
        rf_req.wdata = dec.u_imm;
      end
      rv_pkg::EXEC: begin
        case (dec.opcode)
          `RV_OP_ARITH, `RV_OP_IARITH: rf_req.we = 1'b1;
          `RV_OP_JAL: begin
            rf_req.we    = 1'b1;
            rf_req.wdata = link;
          end
          default: rf_req.we = 1'b0;
        endcase
      end
      rv_pkg::MEM: begin
        rf_req.we    = (dec.opcode == `RV_OP_LOAD);
        rf_req.wdata = mem_rdata;
      end
      default: rf_req.we = 1'b0;
    endcase
  end

  // Stage sequence and bus registers. raddr holds the next pc in the last stage
  always_ff @(posedge clk) begin
    if (rstn) begin
      stage   <= rv_pkg::FETCH;
      pc      <= `RV_RESET_PC;
      mem_req <= '{raddr: `RV_RESET_PC, default: '0};
    end else begin
      mem_req.we <= 1'b0;
      case (stage)
        rv_pkg::FETCH: begin
          mem_req.raddr <= pc_step;
          stage         <= rv_pkg::REG;
        end
        rv_pkg::REG: begin
          if (ends_in_reg) begin
            pc    <= mem_req.raddr;
            stage <= rv_pkg::FETCH;
          end else begin
            if (dec.opcode == `RV_OP_JAL) begin
              mem_req.raddr <= jump_sum;
            end
            stage <= rv_pkg::EXEC;
          end
        end
        rv_pkg::EXEC: begin
          stage <= rv_pkg::RESOLVE;
          case (dec.opcode)
            `RV_OP_JAL: begin
              pc    <= mem_req.raddr;
              stage <= rv_pkg::FETCH;
            end
            `RV_OP_BRANCH: begin
              if (taken) begin
                mem_req.raddr <= target;
              end
            end
            `RV_OP_LOAD: mem_req.raddr <= alu_rsp.res;
            default: ;
          endcase
        end
        rv_pkg::RESOLVE: begin
          case (dec.opcode)
            `RV_OP_LOAD: begin
              mem_req.raddr <= link;   // Back to the fetch address for MEM
              stage         <= rv_pkg::MEM;
            end
            `RV_OP_STORE: begin
              mem_req.waddr <= alu_rsp.res;
              mem_req.wdata <= rs2_data;
              mem_req.we    <= 1'b1;
              stage         <= rv_pkg::MEM;
            end
            default: begin
              pc    <= mem_req.raddr;
              stage <= rv_pkg::FETCH;
            end
          endcase
        end
        rv_pkg::MEM: begin
          pc    <= mem_req.raddr;
          stage <= rv_pkg::FETCH;
        end
        default: stage <= rv_pkg::FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (stage)
      rv_pkg::FETCH: begin
        ir   <= mem_rdata;
        link <= pc_step;
      end
      rv_pkg::REG: begin
        target        <= jump_sum;
        alu_req.a     <= rs1_data;
        alu_req.b     <= rs2_data;
        alu_req.op    <= `RV_F3_ADD;
        alu_req.sub   <= 1'b0;
        alu_req.arith <= dec.alt;
        alu_req.shamt <= rs2_data[`RV_REG_W-1:0];
        case (dec.opcode)
          `RV_OP_ARITH: begin
            alu_req.op  <= dec.funct3;
            alu_req.sub <= dec.alt;
          end
          `RV_OP_IARITH: begin
            alu_req.b     <= dec.i_imm;
            alu_req.op    <= dec.funct3;
            alu_req.shamt <= dec.rs2;   // shamt field of the immediate
          end
          `RV_OP_LOAD:  alu_req.b <= dec.i_imm;
          `RV_OP_STORE: alu_req.b <= dec.s_imm;
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
// Top level of the multi-cycle RV32I core. Connects the stage controller,
// decoder, ALU and register file. Memory sits outside on mem_req / mem_rdata.
`default_nettype none
`timescale 1ns/100ps

module rv_core (
  input  logic             clk,
  input  logic             rstn,
  input  rv_pkg::word_t    mem_rdata,
  output rv_pkg::mem_req_t mem_req
);

  rv_pkg::word_t    ir;
  rv_pkg::dec_t     dec;
  rv_pkg::alu_req_t alu_req;
  rv_pkg::alu_rsp_t alu_rsp;
  rv_pkg::rf_req_t  rf_req;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;

  rv_control u_control (
    .clk       (clk),
    .rstn      (rstn),
    .dec       (dec),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .alu_rsp   (alu_rsp),
    .mem_rdata (mem_rdata),
    .ir        (ir),
    .alu_req   (alu_req),
    .rf_req    (rf_req),
    .mem_req   (mem_req)
  );

  rv_decode u_decode (
    .ir  (ir),
    .dec (dec)
  );

  rv_alu u_alu (
    .req (alu_req),
    .rsp (alu_rsp)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rstn     (rstn),
    .req      (rf_req),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

endmodule

`default_nettype wire

//--- rtl/rv_decode.sv
// Instruction decoder. Splits the instruction register into its fields
// and builds the sign-extended immediates, all combinationally.
`default_nettype none
`timescale 1ns/100ps

`include "rv_consts.svh"

module rv_decode (
  input  rv_pkg::word_t ir,
  output rv_pkg::dec_t  dec
);

  logic sign;

  assign sign = ir[`RV_SIGN_BIT];

  always_comb begin
    dec.opcode = ir[`RV_OPC_LSB +: 7];
    dec.funct3 = ir[`RV_F3_LSB +: 3];
    dec.rd     = ir[`RV_RD_LSB +: `RV_REG_W];
    dec.rs1    = ir[`RV_RS1_LSB +: `RV_REG_W];
    dec.rs2    = ir[`RV_RS2_LSB +: `RV_REG_W];
    dec.alt    = ir[`RV_ALT_BIT];

    // 12-bit immediates, 20 sign bits on top
    dec.i_imm = {{20{sign}}, ir[`RV_SIGN_BIT:`RV_RS2_LSB]};
    dec.s_imm = {{20{sign}}, ir[`RV_SIGN_BIT:`RV_F7_LSB], ir[`RV_F3_LSB-1:`RV_RD_LSB]};

    // Branch offset, bit 11 sits in the rd field
    dec.b_imm = {{20{sign}},
                 ir[`RV_RD_LSB],
                 ir[`RV_SIGN_BIT-1:`RV_F7_LSB],
                 ir[`RV_F3_LSB-1:`RV_RD_LSB+1],
                 1'b0};

    // Jump offset, bits 19:12 stay in place
    dec.j_imm = {{12{sign}},
                 ir[`RV_RS2_LSB-1:`RV_F3_LSB],
                 ir[`RV_RS2_LSB],
                 ir[`RV_SIGN_BIT-1:`RV_RS2_LSB+1],
                 1'b0};

    dec.u_imm = {ir[`RV_SIGN_BIT:`RV_F3_LSB], {`RV_F3_LSB{1'b0}}};
  end

endmodule

`default_nettype wire

//--- rtl/rv_pkg.sv
// Shared types of the RV32I core: word typedefs, the stage enum and the
// packed structs that carry the decoder, ALU, register file and memory buses.
`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]  word_t;
  typedef logic [`RV_XLEN-1:0]  addr_t;
  typedef logic [`RV_REG_W-1:0] reg_idx_t;
  typedef logic [6:0]           opcode_t;
  typedef logic [2:0]           funct3_t;

  typedef enum logic [2:0] {
    FETCH,
    REG,
    EXEC,
    RESOLVE,
    MEM
  } stage_e;

  typedef struct packed {
    opcode_t  opcode;
    funct3_t  funct3;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     alt;
    word_t    i_imm;
    word_t    s_imm;
    word_t    u_imm;
    word_t    b_imm;
    word_t    j_imm;
  } dec_t;

  typedef struct packed {
    word_t    a;
    word_t    b;
    funct3_t  op;
    logic     sub;
    logic     arith;
    reg_idx_t shamt;
  } alu_req_t;

  typedef struct packed {
    word_t res;
    logic  eq;
    logic  lt;   // signed
    logic  ltu;
  } alu_rsp_t;

  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     we;
    word_t    wdata;
  } rf_req_t;

  typedef struct packed {
    addr_t raddr;
    addr_t waddr;
    word_t wdata;
    logic  we;
  } mem_req_t;

endpackage

`default_nettype wire

//--- rtl/rv_regfile.sv
// 32-entry integer register file, two combinational read ports and one
// write port. All registers clear on reset and x0 is never written.
`default_nettype none
`timescale 1ns/100ps

`include "rv_consts.svh"

module rv_regfile (
  input  logic            clk,
  input  logic            rstn,
  input  rv_pkg::rf_req_t req,
  output rv_pkg::word_t   rs1_data,
  output rv_pkg::word_t   rs2_data
);

  localparam int NUM_REGS = 1 << `RV_REG_W;

  rv_pkg::word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rstn) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (req.we && req.rd != '0) begin   // x0 stays zero
      regs[req.rd] <= req.wdata;
    end
  end

  assign rs1_data = regs[req.rs1];
  assign rs2_data = regs[req.rs2];

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/rv_decode.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_control.sv
rtl/rv_core.sv
verification/rv_core_assertions.sv
verification/rv_core_tb.sv

//--- verification/rv_core_assertions.sv
// Memory bus checks for the stage controller, bound to every rv_control.
`default_nettype none
`timescale 1ns/100ps

module rv_core_assertions (
  input logic             clk,
  input logic             rstn,
  input rv_pkg::mem_req_t mem_req
);

  int fail_count = 0;

  // Store strobe lasts one cycle
  we_single_cycle: assert property (@(posedge clk) disable iff (rstn)
    mem_req.we |=> !mem_req.we)
    else begin
      fail_count++;
      $error("write strobe high for two cycles");
    end

  we_low_after_reset: assert property (@(posedge clk) rstn |=> !mem_req.we)
    else begin
      fail_count++;
      $error("write strobe high right after reset");
    end

  raddr_known: assert property (@(posedge clk) disable iff (rstn)
    !$isunknown(mem_req.raddr))
    else begin
      fail_count++;
      $error("read address has unknown bits");
    end

endmodule

bind rv_control rv_core_assertions u_assertions (
  .clk     (clk),
  .rstn    (rstn),
  .mem_req (mem_req)
);

`default_nettype wire

//--- verification/rv_core_golden.hex
// Words 0-20: program image from address 0. Word 21: store count N.
// Then N pairs of lines: expected waddr, expected wdata.
123450B7 // lui   x1, 0x12345
FFD00113 // addi  x2, x0, -3
402081B3 // sub   x3, x1, x2
40115213 // srai  x4, x2, 1
01C15293 // srli  x5, x2, 28
00519333 // sll   x6, x3, x5
005223B3 // slt   x7, x4, x5
0042B433 // sltu  x8, x5, x4
004344B3 // xor   x9, x6, x4
0074E533 // or    x10, x9, x7
002575B3 // and   x11, x10, x2
10B02023 // sw    x11, 0x100(x0)
10002603 // lw    x12, 0x100(x0)
0042E463 // bltu  x5, x4, +8   taken
10002223 // sw    x0, 0x104(x0) wrong path
00525463 // bge   x4, x5, +8   not taken
008606B3 // add   x13, x12, x8
0080006F // jal   x0, +8       also writes x0
10002423 // sw    x0, 0x108(x0) skipped
10D02223 // sw    x13, 0x104(x0)
0000006F // jal   x0, 0
00000002
00000100
D7FE7FFD
00000104
D7FE7FFE

//--- verification/rv_core_tb.sv
// Testbench for the multi-cycle RV32I core. Loads the program image from the
// golden file, models a synchronous word memory and checks every store
// against the expected address and data pairs that follow the image.
`default_nettype none
`timescale 1ns/100ps

`include "rv_consts.svh"

module rv_core_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;
  localparam int PROG_WORDS   = 21;
  localparam int MAX_STORES   = 2;
  localparam int GOLDEN_WORDS = PROG_WORDS + 1 + 2 * MAX_STORES;
  localparam int IDLE_CYCLES  = 50;
  localparam int MEM_WORDS    = 1 << (`RV_MEM_AW - 2);
  localparam int TIMEOUT_NS   = (RESET_CYCLES + PROG_WORDS * 5 + IDLE_CYCLES) * CLK_PERIOD;

  logic             clk;
  logic             rstn;
  rv_pkg::word_t    mem_rdata = '0;
  rv_pkg::mem_req_t mem_req;

  rv_pkg::word_t mem    [MEM_WORDS];
  rv_pkg::word_t golden [GOLDEN_WORDS];

  int errors          = 0;
  int stores_seen     = 0;
  int expected_stores = 0;

  rv_core u_dut (
    .clk       (clk),
    .rstn      (rstn),
    .mem_rdata (mem_rdata),
    .mem_req   (mem_req)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Synchronous memory, read data one clock after raddr
  always @(posedge clk) begin
    mem_rdata <= mem[mem_req.raddr[`RV_MEM_AW-1:2]];
    if (mem_req.we) begin
      mem[mem_req.waddr[`RV_MEM_AW-1:2]] <= mem_req.wdata;
    end
  end

  task automatic check_addr(input string name, input rv_pkg::addr_t exp,
                            input rv_pkg::addr_t act);
    if (act !== exp) begin
      $display("** Error: %s expected %h, got %h at %0t", name, exp, act, $time);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input rv_pkg::word_t exp,
                            input rv_pkg::word_t act);
    if (act !== exp) begin
      $display("** Error: %s expected %h, got %h at %0t", name, exp, act, $time);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error: %s expected %h, got %h at %0t", name, exp, act, $time);
      errors++;
    end
  endtask

  task automatic check_reset_outputs();
    check_bit("mem_req.we", 1'b0, mem_req.we);
    check_addr("mem_req.raddr", `RV_RESET_PC, mem_req.raddr);
  endtask

  task automatic load_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'hB000_0000 | (i << 2);   // Unused words show their own address
    end
    $readmemh("verification/rv_core_golden.hex", golden);
    for (int i = 0; i < PROG_WORDS; i++) begin
      mem[i] = golden[i];
    end
    expected_stores = golden[PROG_WORDS];
    if (expected_stores > MAX_STORES) begin
      $display("Golden file asks for %0d stores, only %0d pairs fit", expected_stores,
               MAX_STORES);
      errors++;
      expected_stores = MAX_STORES;
    end
  endtask

  // Each strobe is compared with the next golden pair
  always @(negedge clk) begin
    if (!rstn && mem_req.we) begin
      if (stores_seen < expected_stores) begin
        check_addr("mem_req.waddr", golden[PROG_WORDS + 1 + 2 * stores_seen], mem_req.waddr);
        check_word("mem_req.wdata", golden[PROG_WORDS + 2 + 2 * stores_seen], mem_req.wdata);
      end else begin
        $display("Unexpected store of %h to %h at %0t", mem_req.wdata, mem_req.waddr, $time);
        errors++;
      end
      stores_seen++;
    end
  end

  initial begin
    rstn = 1'b1;
    load_program();
    // Last pass sees the state of the first cycle out of reset
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_reset_outputs();
    end
    rstn = 1'b0;
    wait (stores_seen >= expected_stores);
    repeat (IDLE_CYCLES) @(negedge clk);   // No more strobes allowed here
    errors = errors + u_dut.u_control.u_assertions.fail_count;
    $display("Errors: %0d, stores seen: %0d of %0d", errors, stores_seen, expected_stores);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns with %0d of %0d stores seen", TIMEOUT_NS, stores_seen,
             expected_stores);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
